// File: Bender.yml
package:
  name: gps_channel

sources:
  - files:
      - verilog/gps_code_pkg.sv
      - verilog/gps_reg_pkg.sv
      - verilog/chip_timing_if.sv
      - verilog/demod_ctrl.sv
      - verilog/code_nco.sv
      - verilog/ca_code_gen.sv
      - verilog/correlator.sv
      - verilog/gps_channel.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_gps_channel.sv

// File: build.f
verilog/gps_code_pkg.sv
verilog/gps_reg_pkg.sv
verilog/chip_timing_if.sv
verilog/demod_ctrl.sv
verilog/code_nco.sv
verilog/ca_code_gen.sv
verilog/correlator.sv
verilog/gps_channel.sv
verification/tb_clk_gen.sv
verification/tb_gps_channel.sv

// File: verification/tb_clk_gen.sv
// Testbench clock and synchronous reset source, instantiated once by the channel testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Reset held over the first rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_gps_channel.sv
// Channel testbench: drives the CPU port and IF samples, models chip timing and C/A sums
`timescale 1ns/1ps
`default_nettype none

module tb_gps_channel;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int chip_cycles  = 4;
    localparam int code_len     = gps_code_pkg::ca_code_len;
    localparam int epoch_cycles = code_len * chip_cycles;
    localparam int ser_len      = gps_code_pkg::ser_len;
    localparam int unsigned rand_seed = 17254;
    localparam logic [31:0] rate_4clk = 32'h4000_0000;

    // Epochs used by all tests with margin, covers sat loads and dump reads
    localparam int watchdog_epochs = 40;
    localparam int watchdog_ns = (reset_cycles + watchdog_epochs * epoch_cycles) * clk_period;

    logic                      clk;
    logic                      rst;
    logic                      sample;
    logic                      wr_reg;
    gps_reg_pkg::op_t          op;
    gps_reg_pkg::word_t        tos;
    logic                      cg_resume;
    logic                      shift;
    logic                      sout;
    logic                      epoch;
    gps_code_pkg::chip_idx_t   nchip;

    // Reference state of the code NCO
    logic [63:0]               m_acc;
    logic [31:0]               m_rate;
    logic                      m_run;

    bit                        checking;
    int                        err_count;
    int                        test_err_start;
    int                        tests_passed;
    int                        tests_failed;
    logic [code_len-1:0]       ref_seq;
    int                        load_chip;
    int                        nchip_d1;
    int                        nchip_d2;
    int unsigned               seed_val;

    tb_clk_gen #(.period_ns(clk_period), .reset_cycles(reset_cycles)) clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    gps_channel dut_i (
        .clk       (clk),
        .rst       (rst),
        .sample    (sample),
        .wr_reg    (wr_reg),
        .op        (op),
        .tos       (tos),
        .cg_resume (cg_resume),
        .shift     (shift),
        .sout      (sout),
        .epoch     (epoch),
        .nchip     (nchip)
    );

    ////////////////////
    // Reference functions

    // C/A chips from G1 and G2, stage s of each register held in bit s
    function automatic logic [code_len-1:0] ca_sequence(input logic preload,
                                                        input logic [9:0] sel);
        logic [1:10]         g1;
        logic [1:10]         g2;
        logic                g2_bit;
        logic                fb1;
        logic                fb2;
        logic [code_len-1:0] seq;
        int                  s;
        int                  c;
        for (s = 1; s <= 10; s++) begin
            g1[s] = 1'b1;
            g2[s] = preload ? sel[s-1] : 1'b1;
        end
        for (c = 0; c < code_len; c++) begin
            g2_bit = 1'b0;
            if (preload) begin
                g2_bit = g2[10];
            end else begin
                // Parity over the selected G2 stages
                for (s = 1; s <= 10; s++) begin
                    if (sel[s-1]) begin
                        g2_bit = g2_bit ^ g2[s];
                    end
                end
            end
            seq[c] = g1[10] ^ g2_bit;
            fb1 = g1[3] ^ g1[10];
            fb2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
            for (s = 10; s > 1; s--) begin
                g1[s] = g1[s-1];
                g2[s] = g2[s-1];
            end
            g1[1] = fb1;
            g2[1] = fb2;
        end
        return seq;
    endfunction

    // One epoch of a constant sample against the code, four clocks per chip
    function automatic int expected_sum(input logic [code_len-1:0] seq, input logic smp);
        int acc;
        int c;
        acc = 0;
        for (c = 0; c < code_len; c++) begin
            acc += (seq[c] ^ smp) ? -1 : 1;
        end
        return acc * chip_cycles;
    endfunction

    // Sample on the prompt chip against a code half a chip away
    // Two clocks per chip always match, the other two follow the neighbouring chip
    function automatic int offset_sum(input logic [code_len-1:0] seq);
        int acc;
        int c;
        acc = 0;
        for (c = 0; c < code_len; c++) begin
            acc += 2 + ((seq[c] == seq[(c + 1) % code_len]) ? 2 : -2);
        end
        return acc;
    endfunction

    // Whole chips in the accumulated phase, wrapped to one epoch
    function automatic int expected_chip(input logic [63:0] acc);
        return int'((acc >> 32) % code_len);
    endfunction

    // Sum idx of the dump word, ip first
    function automatic int sum_at(input logic [ser_len-1:0] bits, input int idx);
        gps_code_pkg::integ_t v;
        v = bits[ser_len - 1 - idx * gps_code_pkg::integ_bits -: gps_code_pkg::integ_bits];
        return int'(v);
    endfunction

    function automatic string sum_name(input int idx);
        case (idx)
            0: return "ip";
            1: return "qp";
            2: return "ie";
            3: return "qe";
            4: return "il";
            default: return "ql";
        endcase
    endfunction

    ////////////////////
    // Model and compare

    // Carry rule: phase grows by the rate while the gate is open
    always @(posedge clk) begin
        if (rst) begin
            m_acc  <= '0;
            m_rate <= '0;
            m_run  <= 1'b1;
        end else begin
            if (m_run) begin
                m_acc <= m_acc + m_rate;
            end
            if (wr_reg && op[gps_reg_pkg::op_set_cg_nco]) begin
                m_rate <= tos;
            end
            if (wr_reg && op[gps_reg_pkg::op_set_pause]) begin
                m_run <= 1'b0;
            end else if (!m_run) begin
                m_run <= cg_resume;
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            assert (nchip == expected_chip(m_acc)) else begin
                $display("FAILED %0d ns: nchip is %0d, expected %0d",
                         $time, nchip, expected_chip(m_acc));
                err_count++;
            end
            // Epoch sits in the middle of chip 0
            if (epoch) begin
                assert (nchip == 0) else begin
                    $display("FAILED %0d ns: epoch with nchip %0d", $time, nchip);
                    err_count++;
                end
            end
        end
    end

    ////////////////////
    // Stimulus tasks

    task automatic write_reg(input int bit_pos, input gps_reg_pkg::word_t w);
        wr_reg      = 1'b1;
        op          = '0;
        op[bit_pos] = 1'b1;
        tos         = w;
        @(negedge clk);
        wr_reg = 1'b0;
        op     = '0;
        tos    = '0;
    endtask

    // Sample follows nchip two cycles late, which lines it up with the prompt chip
    task automatic step(input bit follow);
        if (follow) begin
            sample = ref_seq[(nchip_d2 - load_chip + code_len) % code_len];
        end
        nchip_d2 = nchip_d1;
        nchip_d1 = nchip;
        @(negedge clk);
    endtask

    task automatic wait_epoch(input bit follow, output int gap);
        gap = 0;
        do begin
            step(follow);
            gap++;
        end while (!epoch && gap < 2 * epoch_cycles);
        assert (epoch) else begin
            $display("No epoch strobe within %0d cycles at %0d ns", gap, $time);
            err_count++;
        end
    endtask

    // Ends on the falling edge where the serial register holds the last sums
    task automatic run_epochs(input int n, input bit follow);
        int gap;
        repeat (n) wait_epoch(follow, gap);
        step(follow);
        step(follow);
    endtask

    task automatic read_dump(output logic [ser_len-1:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < ser_len; i++) begin
            bits  = {bits[ser_len-2:0], sout};
            shift = (i < ser_len - 1);
            @(negedge clk);
        end
    endtask

    task automatic check_all(input logic [ser_len-1:0] bits, input int exp);
        int i;
        for (i = 0; i < gps_code_pkg::n_integ; i++) begin
            assert (sum_at(bits, i) == exp) else begin
                $display("FAILED %0d ns: %s sum is %0d, expected %0d",
                         $time, sum_name(i), sum_at(bits, i), exp);
                err_count++;
            end
        end
    endtask

    // Stops the chip count, reloads the code and records the chip where it restarted
    task automatic load_sat(input logic preload, input logic [9:0] sel);
        gps_reg_pkg::word_t w;
        w = '0;
        w[gps_reg_pkg::sat_g2_init_bit] = preload;
        w[gps_reg_pkg::sat_init_msb:gps_reg_pkg::sat_init_lsb] = sel;
        ref_seq = ca_sequence(preload, sel);
        write_reg(gps_reg_pkg::op_set_cg_nco, '0);
        write_reg(gps_reg_pkg::op_set_sat, w);
        step(1'b0);
        step(1'b0);
        load_chip = nchip;
        nchip_d1  = nchip;
        nchip_d2  = nchip;
        write_reg(gps_reg_pkg::op_set_cg_nco, rate_4clk);
    endtask

    task automatic start_test();
        test_err_start = err_count;
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_err_start) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, err_count - test_err_start);
        end
    endtask

    ////////////////////
    // Test sequence

    initial begin
        logic [ser_len-1:0] bits;
        int                 prev;
        int                 wraps;
        int                 held;
        int                 gap;
        int                 k;
        int                 i;
        logic               preload;
        seed_val     = $urandom(rand_seed);
        sample       = 1'b0;
        wr_reg       = 1'b0;
        op           = '0;
        tos          = '0;
        cg_resume    = 1'b0;
        shift        = 1'b0;
        checking     = 1'b0;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_chip    = 0;
        nchip_d1     = 0;
        nchip_d2     = 0;
        ref_seq      = '0;
        wait (rst == 1'b0);
        @(negedge clk);
        checking = 1'b1;

        // Quiet channel with a zero code rate
        start_test();
        repeat (20) begin
            @(negedge clk);
            assert (!epoch && nchip == 0) else begin
                $display("FAILED %0d ns: epoch %0b nchip %0d after reset", $time, epoch, nchip);
                err_count++;
            end
        end
        finish_test("reset");

        // Four clocks per chip through one wrap, then random slower rates
        start_test();
        write_reg(gps_reg_pkg::op_set_cg_nco, rate_4clk);
        prev  = nchip;
        wraps = 0;
        repeat (epoch_cycles + 200) begin
            @(negedge clk);
            if (prev == code_len - 1 && nchip == 0) begin
                wraps++;
            end
            prev = nchip;
        end
        assert (wraps == 1) else begin
            $display("FAILED %0d ns: nchip wrapped %0d times from 1022 to 0, expected once",
                     $time, wraps);
            err_count++;
        end
        for (k = 0; k < 3; k++) begin
            write_reg(gps_reg_pkg::op_set_cg_nco, ($urandom & 32'h3fff_ffff) | 32'h0100_0000);
            repeat (1500) @(negedge clk);
        end
        write_reg(gps_reg_pkg::op_set_cg_nco, rate_4clk);
        finish_test("chip rate");

        // Code slew by pause and resume
        start_test();
        write_reg(gps_reg_pkg::op_set_pause, '0);
        held = nchip;
        repeat (10 + $urandom % 40) begin
            @(negedge clk);
            assert (nchip == held) else begin
                $display("FAILED %0d ns: nchip moved to %0d while paused", $time, nchip);
                err_count++;
            end
        end
        cg_resume = 1'b1;
        @(negedge clk);
        cg_resume = 1'b0;
        repeat (8) @(negedge clk);
        assert (nchip != held) else begin
            $display("nchip did not resume after cg_resume at %0d ns", $time);
            err_count++;
        end
        finish_test("pause");

        // One-cycle epoch every 1023 chips
        start_test();
        wait_epoch(1'b0, gap);
        for (k = 0; k < 2; k++) begin
            step(1'b0);
            assert (!epoch) else begin
                $display("Epoch stayed high for more than one cycle at %0d ns", $time);
                err_count++;
            end
            wait_epoch(1'b0, gap);
            assert (gap + 1 == epoch_cycles) else begin
                $display("FAILED %0d ns: epoch spacing %0d, expected %0d",
                         $time, gap + 1, epoch_cycles);
                err_count++;
            end
        end
        finish_test("epoch");

        // Constant sample, both satellite modes
        start_test();
        for (k = 0; k < 4; k++) begin
            preload = (k % 2 == 0);
            load_sat(preload, 10'($urandom));
            sample = 1'b0;
            run_epochs(3, 1'b0);
            read_dump(bits);
            check_all(bits, expected_sum(ref_seq, 1'b0));
            sample = 1'b1;
            run_epochs(2, 1'b0);
            read_dump(bits);
            check_all(bits, expected_sum(ref_seq, 1'b1));
        end
        sample = 1'b0;
        finish_test("epoch sums");

        // Sample replays the code so both prompt sums reach near full scale
        // Early and late sit half a chip off the sample
        start_test();
        for (k = 0; k < 2; k++) begin
            load_sat(k == 0, 10'($urandom));
            run_epochs(3, 1'b1);
            read_dump(bits);
            for (i = 0; i < gps_code_pkg::n_integ; i++) begin
                if (i < 2) begin
                    assert (sum_at(bits, i) >= epoch_cycles - 16) else begin
                        $display("FAILED %0d ns: %s sum %0d below %0d",
                                 $time, sum_name(i), sum_at(bits, i), epoch_cycles - 16);
                        err_count++;
                    end
                end else begin
                    assert (sum_at(bits, i) == offset_sum(ref_seq)) else begin
                        $display("FAILED %0d ns: %s sum is %0d, expected %0d",
                                 $time, sum_name(i), sum_at(bits, i), offset_sum(ref_seq));
                        err_count++;
                    end
                end
            end
        end
        finish_test("code match");

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Run limit from the epochs the tests need
    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/ca_code_gen.sv
// GPS C/A Gold code generator, G1 and G2 LFSRs with G2 preload or G2 tap-mask selection
`timescale 1ns/1ps
`default_nettype none

module ca_code_gen (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    g2_init,
    input  gps_code_pkg::chip_idx_t init,
    input  logic                    sat_load,
    chip_timing_if.codegen          tim
);

    // Stage k of each LFSR sits in bit k-1
    logic [9:0] g1;
    logic [9:0] g2;
    logic       g1_fb;
    logic       g2_fb;
    logic       g2_out;

    ////////////////////
    // Feedback

    // G1 taps 3 and 10
    assign g1_fb = g1[2] ^ g1[9];

    // G2 taps 2, 3, 6, 8, 9 and 10
    assign g2_fb = g2[1] ^ g2[2] ^ g2[5] ^ g2[7] ^ g2[8] ^ g2[9];

    ////////////////////
    // Output

    // Preload mode reads stage 10, tap mode takes parity of selected stages
    assign g2_out = g2_init ? g2[9] : ^(g2 & init);

    assign tim.code_e = g1[9] ^ g2_out;

    ////////////////////
    // Shift registers

    always_ff @(posedge clk) begin
        if (rst || sat_load) begin
            g1 <= '1;
            // All ones too when init is a tap mask
            g2 <= g2_init ? init : '1;
        end else if (tim.chip_en) begin
            g1 <= {g1[8:0], g1_fb};
            g2 <= {g2[8:0], g2_fb};
        end
    end

endmodule

`default_nettype wire

// File: verilog/chip_timing_if.sv
// Chip timing bundle between the channel control block, code NCO, code generator and correlator
`timescale 1ns/1ps
`default_nettype none

interface chip_timing_if (
    input logic clk
);

    // Carries out of code NCO bits 30 and 31
    logic half_chip;
    logic full_chip;

    // Full chip with the pause gate applied
    logic chip_en;

    // Early, prompt and late code chips
    logic code_e;
    logic code_p;
    logic code_l;

    // One cycle after epoch
    logic dump;

    modport nco (
        input  clk,
        output half_chip, full_chip
    );

    modport ctrl (
        input  clk, half_chip, full_chip, code_e,
        output chip_en, code_p, code_l, dump
    );

    modport codegen (
        input  clk, chip_en,
        output code_e
    );

    modport corr (
        input  clk, code_e, code_p, code_l, dump
    );

endinterface

`default_nettype wire

// File: verilog/code_nco.sv
// Code phase NCO, a 32-bit accumulator whose top two carries mark half and full chips
`timescale 1ns/1ps
`default_nettype none

module code_nco (
    input  logic                 clk,
    input  logic                 rst,
    input  gps_code_pkg::phase_t cg_rate,
    input  logic                 run,
    chip_timing_if.nco           tim
);

    gps_code_pkg::phase_t phase;
    logic [32:0]          sum;

    // Bit 32 is the carry out of bit 31
    assign sum = {1'b0, phase} + {1'b0, cg_rate};

    // Full chip, wrap of the whole phase
    assign tim.full_chip = sum[32];
    // Carry into bit 31 recovered from the sum bit
    assign tim.half_chip = sum[31] ^ phase[31] ^ cg_rate[31];

    ////////////////////
    // Phase register

    // Frozen while the code is paused
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else if (run) begin
            phase <= sum[31:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/correlator.sv
// Correlator: carrier NCO, early/prompt/late I and Q mixers, epoch integrators and serial dump
`timescale 1ns/1ps
`default_nettype none

module correlator (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample,
    input  gps_code_pkg::phase_t lo_rate,
    input  logic                 shift,
    output logic                 sout,
    chip_timing_if.corr          tim
);

    gps_code_pkg::phase_t lo_phase;
    logic                 lo_i;
    logic                 lo_q;

    // Index order ip, qp, ie, qe, il, ql
    logic [gps_code_pkg::n_integ-1:0] mix;
    gps_code_pkg::integ_t             integ [gps_code_pkg::n_integ];
    logic [gps_code_pkg::ser_len-1:0] ser;

    ////////////////////
    // Carrier NCO

    always_ff @(posedge clk) begin
        if (rst) begin
            lo_phase <= '0;
        end else begin
            lo_phase <= lo_phase + lo_rate;
        end
    end

    // Quadrant patterns 0011 for I and 0110 for Q, both 0 at phase 0
    assign lo_i = lo_phase[31];
    assign lo_q = lo_phase[31] ^ lo_phase[30];

    ////////////////////
    // Mixers

    always_ff @(posedge clk) begin
        mix[0] <= sample ^ tim.code_p ^ lo_i;
        mix[1] <= sample ^ tim.code_p ^ lo_q;
        mix[2] <= sample ^ tim.code_e ^ lo_i;
        mix[3] <= sample ^ tim.code_e ^ lo_q;
        mix[4] <= sample ^ tim.code_l ^ lo_i;
        mix[5] <= sample ^ tim.code_l ^ lo_q;
    end

    ////////////////////
    // Integrators

    // A 0 product counts up, a 1 product counts down
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < gps_code_pkg::n_integ; i++) begin
                integ[i] <= '0;
            end
        end else begin
            for (int i = 0; i < gps_code_pkg::n_integ; i++) begin
                // Dump restarts the sum at the current product
                integ[i] <= (tim.dump ? gps_code_pkg::integ_t'(0) : integ[i])
                            + (mix[i] ? gps_code_pkg::integ_t'(-1) : gps_code_pkg::integ_t'(1));
            end
        end
    end

    ////////////////////
    // Serial dump

    // Captures the finished sums, ip first and MSB first
    always_ff @(posedge clk) begin
        if (tim.dump) begin
            for (int i = 0; i < gps_code_pkg::n_integ; i++) begin
                ser[gps_code_pkg::ser_len - 1 - i * gps_code_pkg::integ_bits
                    -: gps_code_pkg::integ_bits] <= integ[i];
            end
        end else if (shift) begin
            ser <= ser << 1;
        end
    end

    assign sout = ser[gps_code_pkg::ser_len-1];

endmodule

`default_nettype wire

// File: verilog/demod_ctrl.sv
// Channel control: register decode, code pause, chip count, epoch and prompt/late chip timing
`timescale 1ns/1ps
`default_nettype none

module demod_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_reg,
    input  gps_reg_pkg::op_t        op,
    input  gps_reg_pkg::word_t      tos,
    input  logic                    cg_resume,
    output gps_code_pkg::phase_t    lo_rate,
    output gps_code_pkg::phase_t    cg_rate,
    output logic                    g2_init,
    output gps_code_pkg::chip_idx_t init,
    output logic                    sat_load,
    output logic                    cg_en,
    output gps_code_pkg::chip_idx_t nchip,
    output logic                    epoch,
    chip_timing_if.ctrl             tim
);

    ////////////////////
    // Register writes

    always_ff @(posedge clk) begin
        if (rst) begin
            lo_rate  <= '0;
            cg_rate  <= '0;
            g2_init  <= 1'b1;
            init     <= '1;
            sat_load <= 1'b0;
        end else begin
            if (wr_reg && op[gps_reg_pkg::op_set_lo_nco]) begin
                lo_rate <= tos;
            end
            if (wr_reg && op[gps_reg_pkg::op_set_cg_nco]) begin
                cg_rate <= tos;
            end
            if (wr_reg && op[gps_reg_pkg::op_set_sat]) begin
                g2_init <= tos[gps_reg_pkg::sat_g2_init_bit];
                init    <= tos[gps_reg_pkg::sat_init_msb:gps_reg_pkg::sat_init_lsb];
            end
            // Code generator reloads one cycle later, from the new init
            sat_load <= wr_reg && op[gps_reg_pkg::op_set_sat];
        end
    end

    ////////////////////
    // Code pause

    // Pause write closes the gate, cg_resume reopens it
    always_ff @(posedge clk) begin
        if (rst) begin
            cg_en <= 1'b1;
        end else if (wr_reg && op[gps_reg_pkg::op_set_pause]) begin
            cg_en <= 1'b0;
        end else if (!cg_en) begin
            cg_en <= cg_resume;
        end
    end

    assign tim.chip_en = tim.full_chip & cg_en;

    ////////////////////
    // Chip count, epoch, prompt and late chips

    always_ff @(posedge clk) begin
        if (rst) begin
            nchip      <= '0;
            epoch      <= 1'b0;
            tim.dump   <= 1'b0;
            tim.code_p <= 1'b0;
            tim.code_l <= 1'b0;
        end else begin
            if (tim.chip_en) begin
                nchip <= (nchip == gps_code_pkg::chip_idx_t'(gps_code_pkg::ca_code_len - 1))
                         ? '0 : nchip + 1'b1;
            end
            // Mid chip, early becomes prompt
            if (tim.half_chip && !tim.full_chip) begin
                tim.code_p <= tim.code_e;
            end
            // Chip edge, prompt becomes late
            if (tim.full_chip) begin
                tim.code_l <= tim.code_p;
            end
            // Epoch marks the middle of chip 0
            epoch    <= tim.half_chip && !tim.full_chip && (nchip == '0);
            tim.dump <= epoch;
        end
    end

endmodule

`default_nettype wire

// File: verilog/gps_channel.sv
// GPS L1 C/A correlator channel top level, one instance per tracked satellite
`timescale 1ns/1ps
`default_nettype none

module gps_channel (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sample,
    input  logic                    wr_reg,
    input  gps_reg_pkg::op_t        op,
    input  gps_reg_pkg::word_t      tos,
    input  logic                    cg_resume,
    input  logic                    shift,
    output logic                    sout,
    output logic                    epoch,
    output gps_code_pkg::chip_idx_t nchip
);

    gps_code_pkg::phase_t    lo_rate;
    gps_code_pkg::phase_t    cg_rate;
    logic                    g2_init;
    gps_code_pkg::chip_idx_t init;
    logic                    sat_load;
    logic                    cg_en;

    // Chip strobes and code chips between the blocks
    chip_timing_if tim_if (.clk(clk));

    demod_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .wr_reg    (wr_reg),
        .op        (op),
        .tos       (tos),
        .cg_resume (cg_resume),
        .lo_rate   (lo_rate),
        .cg_rate   (cg_rate),
        .g2_init   (g2_init),
        .init      (init),
        .sat_load  (sat_load),
        .cg_en     (cg_en),
        .nchip     (nchip),
        .epoch     (epoch),
        .tim       (tim_if.ctrl)
    );

    // Code phase stops while paused
    code_nco nco_i (
        .clk     (clk),
        .rst     (rst),
        .cg_rate (cg_rate),
        .run     (cg_en),
        .tim     (tim_if.nco)
    );

    ca_code_gen code_i (
        .clk      (clk),
        .rst      (rst),
        .g2_init  (g2_init),
        .init     (init),
        .sat_load (sat_load),
        .tim      (tim_if.codegen)
    );

    correlator corr_i (
        .clk     (clk),
        .rst     (rst),
        .sample  (sample),
        .lo_rate (lo_rate),
        .shift   (shift),
        .sout    (sout),
        .tim     (tim_if.corr)
    );

endmodule

`default_nettype wire

// File: verilog/gps_code_pkg.sv
// C/A code, NCO phase and integrator definitions shared by the correlator channel datapath
`default_nettype none

package gps_code_pkg;

    ////////////////////
    // Code geometry

    // Chips in one C/A epoch
    localparam int unsigned ca_code_len = 1023;

    // Chip index within an epoch
    typedef logic [9:0] chip_idx_t;

    ////////////////////
    // NCOs

    // Phase accumulator word, also used for the rate
    typedef logic [31:0] phase_t;

    ////////////////////
    // Integrators

    // Holds +/-4092, one epoch at four clocks per chip
    localparam int unsigned integ_bits = 14;
    typedef logic signed [integ_bits-1:0] integ_t;

    // ip, qp, ie, qe, il, ql
    localparam int unsigned n_integ = 6;

    // Serial dump length, all sums back to back
    localparam int unsigned ser_len = n_integ * integ_bits;

endpackage

`default_nettype wire

// File: verilog/gps_reg_pkg.sv
// CPU register port layout: opcode bits, bus word types and satellite select fields
`default_nettype none

package gps_reg_pkg;

    // Opcode and data words from the CPU
    typedef logic [15:0] op_t;
    typedef logic [31:0] word_t;

    ////////////////////
    // Opcode bits, any combination per write
    localparam int unsigned op_set_sat    = 0;
    localparam int unsigned op_set_pause  = 1;
    localparam int unsigned op_set_lo_nco = 2;
    localparam int unsigned op_set_cg_nco = 3;

    ////////////////////
    // Satellite select word
    // G2 initial state or G2 tap mask
    localparam int unsigned sat_init_lsb    = 0;
    localparam int unsigned sat_init_msb    = 9;
    // 1 preloads G2, 0 treats init as a tap mask
    localparam int unsigned sat_g2_init_bit = 10;

endpackage

`default_nettype wire
